/* run.sh */
#!/usr/bin/env bash
# Build and run the vector store testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_vstore -o tb_vstore_sim

./obj_dir/tb_vstore_sim 2>&1 | tee sim.log

if grep -q 'Test failures found' sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"

/* tb_vstore.sv */
// Vector store unit testbench

module tb_vstore;

  localparam int CLK_PERIOD = 4;
  localparam int MEM_AW     = 10;
  localparam int MEM_BYTES  = 1 << MEM_AW;
  // Elements stored over all tests
  localparam int TOTAL_ELEMS     = 4 + 32 + 16 + 128 + 8;
  localparam int WATCHDOG_CYCLES = TOTAL_ELEMS * 40 + 2000;
  localparam logic [31:0] SEED        = 32'hd71793f8;
  localparam logic [31:0] NO_ERR_ADDR = 32'hffff_fffc;

  logic        clk;
  logic        rstn;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [1:0]  cmd_sew;
  logic [1:0]  cmd_lmul;
  logic        cmd_strided;
  logic [31:0] cmd_base;
  logic [31:0] cmd_stride;
  logic        cmd_err;
  logic        lane_valid;
  logic [31:0] lane_data;
  logic        lane_ready;
  logic        awvalid;
  logic        awready;
  logic [31:0] awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        done;
  logic        done_err;

  logic        stall_en;
  logic        stall_aw;
  logic        stall_w;
  logic [31:0] err_addr;
  logic [31:0] lane_rng;
  logic [31:0] stall_rng;
  logic        lane_dropped;
  logic [7:0]  exp_mem [MEM_BYTES];
  logic        done_log [$];
  int          err_pulses;
  int          mismatches;
  int          failures;

  vstore_top vstore_top_i (
    .clk (clk), .rstn (rstn),
    .cmd_valid_i (cmd_valid), .cmd_ready_o (cmd_ready), .cmd_sew_i (cmd_sew),
    .cmd_lmul_i (cmd_lmul), .cmd_strided_i (cmd_strided), .cmd_base_i (cmd_base),
    .cmd_stride_i (cmd_stride), .cmd_err_o (cmd_err),
    .lane_valid_i (lane_valid), .lane_data_i (lane_data), .lane_ready_o (lane_ready),
    .awvalid_o (awvalid), .awready_i (awready), .awaddr_o (awaddr),
    .wvalid_o (wvalid), .wready_i (wready), .wdata_o (wdata), .wstrb_o (wstrb),
    .bvalid_i (bvalid), .bready_o (bready), .bresp_i (bresp),
    .done_o (done), .done_err_o (done_err)
  );

  tb_vstore_axil_mem #(.MEM_AW (MEM_AW)) axil_mem_i (
    .clk (clk), .rstn (rstn),
    .stall_aw_i (stall_aw), .stall_w_i (stall_w), .err_addr_i (err_addr),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Elements per register times registers per group
  function automatic int elem_count(input logic [1:0] sew, input logic [1:0] lmul);
    return (int'(vstore_cfg_pkg::VLEN_BYTES) / (1 << sew)) * (1 << lmul);
  endfunction

  ////////////////////////////////////////////////////////////
  // Slave stalls and monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #1;
    if (stall_en) begin
      stall_rng = xorshift32(stall_rng);
      stall_aw  = stall_rng[0];
      stall_w   = stall_rng[9];
    end else begin
      stall_aw = 1'b0;
      stall_w  = 1'b0;
    end
  end

  // Mid-cycle sampling
  always @(negedge clk) begin
    if (rstn) begin
      if (done) begin
        done_log.push_back(done_err);
      end
      assert (done || !done_err) else begin
        $display("ERROR at %0t: done_err_o pulsed without done_o", $time);
        failures++;
      end
      if (cmd_err) begin
        err_pulses++;
      end
      if (!lane_ready) begin
        lane_dropped = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Checks and drivers
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      $display("ERROR at %0t: %s", $time, what);
      failures++;
    end
  endtask

  task automatic compare_image(input string test);
    for (int a = 0; a < MEM_BYTES; a++) begin
      assert (axil_mem_i.mem[a] === exp_mem[a]) else begin
        $display("MISMATCH time=%0t %s mem[0x%03h] got=0x%02h expected=0x%02h",
                 $time, test, a, axil_mem_i.mem[a], exp_mem[a]);
        mismatches++;
      end
    end
  endtask

  // Entered and left 1 time unit after a rising edge
  task automatic send_cmd(input logic [1:0] sew, input logic [1:0] lmul, input logic strided,
                          input logic [31:0] base, input logic [31:0] stride);
    logic taken;
    cmd_valid   = 1'b1;
    cmd_sew     = sew;
    cmd_lmul    = lmul;
    cmd_strided = strided;
    cmd_base    = base;
    cmd_stride  = stride;
    do begin
      @(negedge clk);
      taken = cmd_ready;
      @(posedge clk);
    end while (!taken);
    #1;
    cmd_valid = 1'b0;
  endtask

  // Streams lane words and places each element in the expected image
  task automatic store_elems(input logic [1:0] sew, input logic [31:0] base,
                             input logic [31:0] step, input int count);
    logic        taken;
    logic [31:0] word;
    logic [31:0] addr;
    for (int i = 0; i < count; i++) begin
      lane_rng   = xorshift32(lane_rng);
      word       = lane_rng;
      lane_valid = 1'b1;
      lane_data  = word;
      do begin
        @(negedge clk);
        taken = lane_ready;
        @(posedge clk);
      end while (!taken);
      #1;
      addr = base + 32'(i) * step;
      // An erroring slave keeps the old bytes
      if (addr[31:2] != err_addr[31:2]) begin
        for (int b = 0; b < (1 << sew); b++) begin
          exp_mem[MEM_AW'(addr + 32'(b))] = word[8*b +: 8];
        end
      end
    end
    lane_valid = 1'b0;
  endtask

  task automatic wait_done(input int target);
    while (done_log.size() < target) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic run_store(input logic [1:0] sew, input logic [1:0] lmul, input logic strided,
                           input logic [31:0] base, input logic [31:0] stride,
                           input string name);
    int          d0;
    int          e0;
    logic [31:0] step;
    d0   = done_log.size();
    e0   = err_pulses;
    // Unit stride steps by the element size
    step = strided ? stride : (32'd1 << sew);
    send_cmd(sew, lmul, strided, base, stride);
    store_elems(sew, base, step, elem_count(sew, lmul));
    wait_done(d0 + 1);
    check_eq({name, " done_o count"}, 32'(done_log.size() - d0), 32'd1);
    check_eq({name, " done_err_o"}, 32'(done_log[$]), 32'd0);
    check_eq({name, " cmd_err_o count"}, 32'(err_pulses - e0), 32'd0);
    compare_image(name);
  endtask

  task automatic reject_cmd(input logic [1:0] sew, input logic [1:0] lmul, input logic strided,
                            input logic [31:0] base, input logic [31:0] stride);
    send_cmd(sew, lmul, strided, base, stride);
    @(negedge clk);
    check_true(cmd_err === 1'b1, "cmd_err_o missing one cycle after an illegal command");
    @(negedge clk);
    check_true(cmd_err === 1'b0, "cmd_err_o stayed high for more than one cycle");
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic unit_word_store();
    // Junk stride field that a unit-stride command ignores
    run_store(2'd2, 2'd0, 1'b0, 32'h100, 32'h13, "unit_word");
  endtask

  task automatic strided_store();
    run_store(2'd0, 2'd1, 1'b1, 32'h203, 32'd5, "strided_byte");
    run_store(2'd1, 2'd1, 1'b1, 32'h302, 32'd6, "strided_half");
  endtask

  task automatic group8_stall_store();
    lane_dropped = 1'b0;
    stall_en     = 1'b1;
    run_store(2'd0, 2'd3, 1'b0, 32'h180, 32'h0, "group8_stall");
    stall_en = 1'b0;
    check_true(lane_dropped, "lane_ready_o never dropped during the long store");
  endtask

  task automatic illegal_cmds();
    int d0;
    int e0;
    d0 = done_log.size();
    e0 = err_pulses;
    reject_cmd(2'd3, 2'd0, 1'b0, 32'h200, 32'h0);
    reject_cmd(2'd2, 2'd0, 1'b0, 32'h202, 32'h0);
    reject_cmd(2'd1, 2'd1, 1'b1, 32'h200, 32'h3);
    repeat (20) @(posedge clk);
    #1;
    check_eq("illegal cmd_err_o count", 32'(err_pulses - e0), 32'd3);
    check_eq("illegal done_o count", 32'(done_log.size() - d0), 32'd0);
    compare_image("illegal");
  endtask

  task automatic back_to_back_cmds();
    int d0;
    d0       = done_log.size();
    err_addr = 32'h068;
    send_cmd(2'd2, 2'd0, 1'b0, 32'h040, 32'h0);
    send_cmd(2'd2, 2'd0, 1'b1, 32'h060, 32'd8);
    store_elems(2'd2, 32'h040, 32'd4, 4);
    store_elems(2'd2, 32'h060, 32'd8, 4);
    wait_done(d0 + 2);
    check_eq("back_to_back done_o count", 32'(done_log.size() - d0), 32'd2);
    check_eq("back_to_back first done_err_o", 32'(done_log[d0]), 32'd0);
    check_eq("back_to_back second done_err_o", 32'(done_log[d0 + 1]), 32'd1);
    compare_image("back_to_back");
    err_addr = NO_ERR_ADDR;
  endtask

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    cmd_valid    = 1'b0;
    cmd_sew      = 2'd0;
    cmd_lmul     = 2'd0;
    cmd_strided  = 1'b0;
    cmd_base     = 32'h0;
    cmd_stride   = 32'h0;
    lane_valid   = 1'b0;
    lane_data    = 32'h0;
    stall_en     = 1'b0;
    stall_aw     = 1'b0;
    stall_w      = 1'b0;
    err_addr     = NO_ERR_ADDR;
    lane_rng     = SEED;
    stall_rng    = SEED;
    lane_dropped = 1'b0;
    err_pulses   = 0;
    mismatches   = 0;
    failures     = 0;
    @(posedge clk);
    @(negedge clk);
    check_true(!cmd_ready && !lane_ready, "ready outputs high during reset");
    check_true(!awvalid && !wvalid && !done && !done_err && !cmd_err,
               "valid or pulse outputs high during reset");
    @(posedge clk);
    #1;
    rstn = 1'b1;
    // Expected image starts from the slave's fill pattern
    for (int a = 0; a < MEM_BYTES; a++) begin
      exp_mem[a] = axil_mem_i.mem[a];
    end
    @(posedge clk);
    #1;
    check_true(cmd_ready && lane_ready, "ready outputs not high after reset");
    unit_word_store();
    strided_store();
    group8_stall_store();
    illegal_cmds();
    back_to_back_cmds();
    $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb_vstore_axil_mem.sv */
// AXI4-Lite slave memory model

module tb_vstore_axil_mem #(
  parameter int MEM_AW = 10
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        stall_aw_i,
  input  logic        stall_w_i,
  input  logic [31:0] err_addr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] awaddr_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic        bvalid_o,
  input  logic        bready_i,
  output logic [1:0]  bresp_o
);

  logic [7:0]  mem [1 << MEM_AW];
  logic [31:0] aw_q [$];
  logic [31:0] wd_q [$];
  logic [3:0]  ws_q [$];
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;

  // Fill pattern over every address bit
  initial begin
    for (int a = 0; a < (1 << MEM_AW); a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    end
  end

  assign awready_o = !stall_aw_i;
  assign wready_o  = !stall_w_i;

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bvalid_o <= 1'b0;
      bresp_o  <= vstore_axi_pkg::RESP_OKAY;
      aw_q.delete();
      wd_q.delete();
      ws_q.delete();
    end else begin
      if (awvalid_i && awready_o) begin
        aw_q.push_back(awaddr_i);
      end
      if (wvalid_i && wready_o) begin
        wd_q.push_back(wdata_i);
        ws_q.push_back(wstrb_i);
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
      // One response per address and data pair, in arrival order
      if ((!bvalid_o || bready_i) && aw_q.size() > 0 && wd_q.size() > 0) begin
        addr = aw_q.pop_front();
        data = wd_q.pop_front();
        strb = ws_q.pop_front();
        bvalid_o <= 1'b1;
        if (addr[31:2] == err_addr_i[31:2]) begin
          bresp_o <= vstore_axi_pkg::RESP_SLVERR;
        end else begin
          bresp_o <= vstore_axi_pkg::RESP_OKAY;
          for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
              mem[{addr[MEM_AW-1:2], 2'(k)}] = data[8*k +: 8];
            end
          end
        end
      end
    end
  end

endmodule

/* vlog.f */
vstore_cfg_pkg.sv
vstore_axi_pkg.sv
vstore_fifo.sv
vstore_cmd_decode.sv
vstore_ctrl.sv
vstore_axil_wr.sv
vstore_top.sv
vstore_sva.sv
tb_vstore_axil_mem.sv
tb_vstore.sv

/* vstore_axi_pkg.sv */
// AXI4-Lite write side definitions

package vstore_axi_pkg;

  // Channel widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  ////////////////////////////////////////////////////////////
  // Write response codes
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Writes allowed in flight before a response returns
  localparam int unsigned MAX_OUTSTANDING = 4;

endpackage

/* vstore_axil_wr.sv */
// AXI4-Lite write master

module vstore_axil_wr (
  input  logic                              clk,
  input  logic                              rstn,
  // Element requests
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  logic [vstore_axi_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [vstore_axi_pkg::DATA_W-1:0] req_data_i,
  input  logic [vstore_axi_pkg::STRB_W-1:0] req_strb_i,
  input  logic                              req_last_i,
  // AW channel
  output logic                              awvalid_o,
  input  logic                              awready_i,
  output logic [vstore_axi_pkg::ADDR_W-1:0] awaddr_o,
  // W channel
  output logic                              wvalid_o,
  input  logic                              wready_i,
  output logic [vstore_axi_pkg::DATA_W-1:0] wdata_o,
  output logic [vstore_axi_pkg::STRB_W-1:0] wstrb_o,
  // B channel
  input  logic                              bvalid_i,
  output logic                              bready_o,
  input  logic [1:0]                        bresp_i,
  // Command completion
  output logic                              done_o,
  output logic                              done_err_o
);

  logic [$clog2(vstore_axi_pkg::MAX_OUTSTANDING + 1)-1:0] outst_q;
  logic req_fire;
  logic b_fire;
  logic resp_bad;
  logic err_q;
  logic head_valid;
  logic head_last;

  assign bready_o = 1'b1;
  assign req_fire = req_valid_i && req_ready_o;
  assign b_fire   = bvalid_i && bready_o;
  assign resp_bad = (bresp_i != vstore_axi_pkg::RESP_OKAY);

  // Both channel registers must drain before the next element
  assign req_ready_o = !awvalid_o && !wvalid_o
                    && (outst_q < vstore_axi_pkg::MAX_OUTSTANDING);

  ////////////////////////////////////////////////////////////
  // Address and data channels
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      awvalid_o <= 1'b0;
      wvalid_o  <= 1'b0;
      outst_q   <= '0;
    end else begin
      if (req_fire) begin
        awvalid_o <= 1'b1;
        wvalid_o  <= 1'b1;
      end else begin
        if (awready_i) awvalid_o <= 1'b0;
        if (wready_i)  wvalid_o  <= 1'b0;
      end
      if (req_fire && !b_fire) begin
        outst_q <= outst_q + 1'b1;
      end else if (b_fire && !req_fire) begin
        outst_q <= outst_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      awaddr_o <= req_addr_i;
      wdata_o  <= req_data_i;
      wstrb_o  <= req_strb_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response tracking
  ////////////////////////////////////////////////////////////

  // Responses come back in order, so the head flag belongs to this B
  vstore_fifo #(
    .payload_t (logic),
    .DEPTH     (vstore_axi_pkg::MAX_OUTSTANDING)
  ) last_fifo (
    .clk         (clk),
    .rstn        (rstn),
    .push_i      (req_fire),
    .push_data_i (req_last_i),
    .full_o      (),
    .pop_i       (b_fire),
    .out_valid_o (head_valid),
    .out_data_o  (head_last)
  );

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      err_q      <= 1'b0;
      done_o     <= 1'b0;
      done_err_o <= 1'b0;
    end else begin
      done_o     <= 1'b0;
      done_err_o <= 1'b0;
      if (b_fire) begin
        if (head_valid && head_last) begin
          done_o     <= 1'b1;
          done_err_o <= err_q || resp_bad;
          err_q      <= 1'b0;
        end else begin
          err_q <= err_q || resp_bad;
        end
      end
    end
  end

endmodule

/* vstore_cfg_pkg.sv */
// Vector store configuration

package vstore_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Vector geometry
  ////////////////////////////////////////////////////////////

  // Bytes in one vector register
  localparam int unsigned VLEN_BYTES = 16;

  // 8-bit elements over a group of 8 registers
  localparam int unsigned MAX_ELEMS = 128;

  // Wide enough to hold MAX_ELEMS itself
  localparam int unsigned CNT_W = $clog2(MAX_ELEMS + 1);

  // Buffer depths
  localparam int unsigned CMD_DEPTH  = 2;
  localparam int unsigned DATA_DEPTH = 16;

  ////////////////////////////////////////////////////////////
  // Command encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEW_8    = 2'd0,
    SEW_16   = 2'd1,
    SEW_32   = 2'd2,
    SEW_RSVD = 2'd3
  } sew_e;

  // Registers per group, as a power of two
  typedef enum logic [1:0] {
    LMUL_1 = 2'd0,
    LMUL_2 = 2'd1,
    LMUL_4 = 2'd2,
    LMUL_8 = 2'd3
  } lmul_e;

  typedef enum logic {
    KIND_UNIT    = 1'b0,
    KIND_STRIDED = 1'b1
  } store_kind_e;

  // Decoded command as held in the command FIFO
  typedef struct packed {
    store_kind_e      kind;
    sew_e             sew;
    logic [31:0]      base;
    logic [31:0]      stride;
    logic [CNT_W-1:0] count;
  } store_cmd_t;

endpackage

/* vstore_cmd_decode.sv */
// Vector store command decoder

module vstore_cmd_decode (
  input  logic                       clk,
  input  logic                       rstn,
  // Scheduler side
  input  logic                       cmd_valid_i,
  output logic                       cmd_ready_o,
  input  logic [1:0]                 cmd_sew_i,
  input  logic [1:0]                 cmd_lmul_i,
  input  logic                       cmd_strided_i,
  input  logic [31:0]                cmd_base_i,
  input  logic [31:0]                cmd_stride_i,
  output logic                       cmd_err_o,
  // Command FIFO side
  output logic                       push_o,
  output vstore_cfg_pkg::store_cmd_t push_cmd_o,
  input  logic                       full_i
);

  logic                             cmd_fire;
  logic                             legal;
  logic [31:0]                      elem_bytes;
  logic [31:0]                      align_mask;
  logic [31:0]                      per_reg;
  logic [vstore_cfg_pkg::CNT_W-1:0] elem_cnt;
  vstore_cfg_pkg::lmul_e            lmul;
  vstore_cfg_pkg::store_kind_e      kind;

  // A pending push still takes a FIFO slot, so take one command
  // at a time toward the FIFO
  assign cmd_ready_o = !full_i && !push_o;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  ////////////////////////////////////////////////////////////
  // Legality checks
  ////////////////////////////////////////////////////////////

  assign elem_bytes = 32'd1 << cmd_sew_i;
  assign align_mask = elem_bytes - 32'd1;
  assign kind       = cmd_strided_i ? vstore_cfg_pkg::KIND_STRIDED
                                    : vstore_cfg_pkg::KIND_UNIT;

  // Stride only matters for strided commands
  assign legal = (cmd_sew_i != vstore_cfg_pkg::SEW_RSVD)
              && ((cmd_base_i & align_mask) == 32'd0)
              && ((kind == vstore_cfg_pkg::KIND_UNIT)
                  || ((cmd_stride_i & align_mask) == 32'd0));

  // Elements per register times registers per group
  assign lmul     = vstore_cfg_pkg::lmul_e'(cmd_lmul_i);
  assign per_reg  = vstore_cfg_pkg::VLEN_BYTES >> cmd_sew_i;
  assign elem_cnt = per_reg[vstore_cfg_pkg::CNT_W-1:0] << lmul;

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      push_o    <= 1'b0;
      cmd_err_o <= 1'b0;
    end else begin
      push_o    <= cmd_fire && legal;
      cmd_err_o <= cmd_fire && !legal;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && legal) begin
      push_cmd_o.kind  <= kind;
      push_cmd_o.sew   <= vstore_cfg_pkg::sew_e'(cmd_sew_i);
      push_cmd_o.base  <= cmd_base_i;
      // Unit stride walks one element at a time
      push_cmd_o.stride <= (kind == vstore_cfg_pkg::KIND_STRIDED) ? cmd_stride_i
                                                                  : elem_bytes;
      push_cmd_o.count <= elem_cnt;
    end
  end

endmodule

/* vstore_ctrl.sv */
// Vector store element controller

module vstore_ctrl (
  input  logic                              clk,
  input  logic                              rstn,
  // Command FIFO head
  input  logic                              cmd_valid_i,
  input  vstore_cfg_pkg::store_cmd_t        cmd_i,
  output logic                              cmd_pop_o,
  // Lane data FIFO head
  input  logic                              data_valid_i,
  input  logic [vstore_axi_pkg::DATA_W-1:0] data_i,
  output logic                              data_pop_o,
  // Requests toward the write master
  output logic                              req_valid_o,
  input  logic                              req_ready_i,
  output logic [vstore_axi_pkg::ADDR_W-1:0] req_addr_o,
  output logic [vstore_axi_pkg::DATA_W-1:0] req_data_o,
  output logic [vstore_axi_pkg::STRB_W-1:0] req_strb_o,
  output logic                              req_last_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_STREAM
  } state_e;

  state_e                            state_q;
  state_e                            state_d;
  logic [vstore_cfg_pkg::CNT_W-1:0]  remain_q;
  logic [vstore_axi_pkg::ADDR_W-1:0] addr_q;
  logic [31:0]                       stride_q;
  vstore_cfg_pkg::sew_e              sew_q;
  logic [vstore_axi_pkg::STRB_W-1:0] elem_strb;
  logic                              req_fire;
  logic                              last_elem;

  ////////////////////////////////////////////////////////////
  // Command sequencing
  ////////////////////////////////////////////////////////////

  assign req_fire  = req_valid_o && req_ready_i;
  assign last_elem = (remain_q == vstore_cfg_pkg::CNT_W'(1));

  always_comb begin
    state_d   = state_q;
    cmd_pop_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          state_d = ST_LOAD;
        end
      end
      ST_LOAD: begin
        cmd_pop_o = 1'b1;
        state_d   = ST_STREAM;
      end
      ST_STREAM: begin
        // Go straight on to the next command if one is waiting
        if (req_fire && last_elem) begin
          state_d = cmd_valid_i ? ST_LOAD : ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state_q  <= ST_IDLE;
      remain_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_LOAD) begin
        remain_q <= cmd_i.count;
      end else if (req_fire) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  // Running address for the element at the data FIFO head
  always_ff @(posedge clk) begin
    if (state_q == ST_LOAD) begin
      addr_q   <= cmd_i.base;
      stride_q <= cmd_i.stride;
      sew_q    <= cmd_i.sew;
    end else if (req_fire) begin
      addr_q <= addr_q + stride_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Element placement
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (sew_q)
      vstore_cfg_pkg::SEW_8:  elem_strb = 4'b0001;
      vstore_cfg_pkg::SEW_16: elem_strb = 4'b0011;
      default:                elem_strb = 4'b1111;
    endcase
  end

  // Data waits at the FIFO head until the request is taken
  assign req_valid_o = (state_q == ST_STREAM) && data_valid_i;
  assign data_pop_o  = req_fire;
  assign req_addr_o  = addr_q;
  assign req_strb_o  = elem_strb << addr_q[1:0];
  assign req_data_o  = data_i << {addr_q[1:0], 3'b000};
  assign req_last_o  = last_elem;

endmodule

/* vstore_fifo.sv */
// Synchronous FIFO

module vstore_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     push_i,
  input  payload_t push_data_i,
  output logic     full_o,
  input  logic     pop_i,
  output logic     out_valid_o,
  output payload_t out_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push_ok;
  logic             pop_ok;

  assign push_ok     = push_i && !full_o;
  assign pop_ok      = pop_i && out_valid_o;
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push_ok && !pop_ok) begin
      count_next = count + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count_next = count - 1'b1;
    end
  end

  // Full is registered and held high through reset
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full_o <= 1'b1;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count_next;
      full_o <= (count_next == CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule

/* vstore_sva.sv */
// Write master protocol checks

module vstore_sva (
  input logic                                                   clk,
  input logic                                                   rstn,
  input logic                                                   awvalid_i,
  input logic                                                   awready_i,
  input logic [vstore_axi_pkg::ADDR_W-1:0]                      awaddr_i,
  input logic                                                   wvalid_i,
  input logic                                                   wready_i,
  input logic [vstore_axi_pkg::DATA_W-1:0]                      wdata_i,
  input logic [vstore_axi_pkg::STRB_W-1:0]                      wstrb_i,
  input logic [$clog2(vstore_axi_pkg::MAX_OUTSTANDING + 1)-1:0] outst_i
);

  aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("AW channel dropped or changed before AWREADY");

  w_hold: assert property (@(posedge clk) disable iff (!rstn)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else $error("W channel dropped or changed before WREADY");

  outst_limit: assert property (@(posedge clk) disable iff (!rstn)
    32'(outst_i) <= vstore_axi_pkg::MAX_OUTSTANDING)
    else $error("More writes in flight than the write master allows");

endmodule

bind vstore_axil_wr vstore_sva vstore_sva_i (
  .clk (clk), .rstn (rstn),
  .awvalid_i (awvalid_o), .awready_i (awready_i), .awaddr_i (awaddr_o),
  .wvalid_i (wvalid_o), .wready_i (wready_i), .wdata_i (wdata_o), .wstrb_i (wstrb_o),
  .outst_i (outst_q)
);

/* vstore_top.sv */
// Vector store unit top level

module vstore_top (
  input  logic                              clk,
  input  logic                              rstn,
  // Scheduler commands
  input  logic                              cmd_valid_i,
  output logic                              cmd_ready_o,
  input  logic [1:0]                        cmd_sew_i,
  input  logic [1:0]                        cmd_lmul_i,
  input  logic                              cmd_strided_i,
  input  logic [31:0]                       cmd_base_i,
  input  logic [31:0]                       cmd_stride_i,
  output logic                              cmd_err_o,
  // Lane store data
  input  logic                              lane_valid_i,
  input  logic [31:0]                       lane_data_i,
  output logic                              lane_ready_o,
  // AXI4-Lite write channels
  output logic                              awvalid_o,
  input  logic                              awready_i,
  output logic [vstore_axi_pkg::ADDR_W-1:0] awaddr_o,
  output logic                              wvalid_o,
  input  logic                              wready_i,
  output logic [vstore_axi_pkg::DATA_W-1:0] wdata_o,
  output logic [vstore_axi_pkg::STRB_W-1:0] wstrb_o,
  input  logic                              bvalid_i,
  output logic                              bready_o,
  input  logic [1:0]                        bresp_i,
  // Completion
  output logic                              done_o,
  output logic                              done_err_o
);

  vstore_cfg_pkg::store_cmd_t        dec_cmd;
  vstore_cfg_pkg::store_cmd_t        head_cmd;
  logic                              dec_push;
  logic                              cmd_full;
  logic                              cmd_valid;
  logic                              cmd_pop;
  logic                              data_full;
  logic                              data_valid;
  logic [31:0]                       data_word;
  logic                              data_pop;
  logic                              req_valid;
  logic                              req_ready;
  logic [vstore_axi_pkg::ADDR_W-1:0] req_addr;
  logic [vstore_axi_pkg::DATA_W-1:0] req_data;
  logic [vstore_axi_pkg::STRB_W-1:0] req_strb;
  logic                              req_last;

  assign lane_ready_o = !data_full;

  vstore_cmd_decode vstore_cmd_decode_i (
    .clk (clk), .rstn (rstn),
    .cmd_valid_i (cmd_valid_i), .cmd_ready_o (cmd_ready_o),
    .cmd_sew_i (cmd_sew_i), .cmd_lmul_i (cmd_lmul_i), .cmd_strided_i (cmd_strided_i),
    .cmd_base_i (cmd_base_i), .cmd_stride_i (cmd_stride_i), .cmd_err_o (cmd_err_o),
    .push_o (dec_push), .push_cmd_o (dec_cmd), .full_i (cmd_full)
  );

  vstore_fifo #(.payload_t (vstore_cfg_pkg::store_cmd_t), .DEPTH (vstore_cfg_pkg::CMD_DEPTH))
  cmd_fifo (
    .clk (clk), .rstn (rstn), .push_i (dec_push), .push_data_i (dec_cmd), .full_o (cmd_full),
    .pop_i (cmd_pop), .out_valid_o (cmd_valid), .out_data_o (head_cmd)
  );

  vstore_fifo #(.payload_t (logic [31:0]), .DEPTH (vstore_cfg_pkg::DATA_DEPTH))
  data_fifo (
    .clk (clk), .rstn (rstn), .push_i (lane_valid_i), .push_data_i (lane_data_i),
    .full_o (data_full), .pop_i (data_pop), .out_valid_o (data_valid), .out_data_o (data_word)
  );

  vstore_ctrl vstore_ctrl_i (
    .clk (clk), .rstn (rstn),
    .cmd_valid_i (cmd_valid), .cmd_i (head_cmd), .cmd_pop_o (cmd_pop),
    .data_valid_i (data_valid), .data_i (data_word), .data_pop_o (data_pop),
    .req_valid_o (req_valid), .req_ready_i (req_ready), .req_addr_o (req_addr),
    .req_data_o (req_data), .req_strb_o (req_strb), .req_last_o (req_last)
  );

  vstore_axil_wr vstore_axil_wr_i (
    .clk (clk), .rstn (rstn),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_addr_i (req_addr),
    .req_data_i (req_data), .req_strb_i (req_strb), .req_last_i (req_last),
    .awvalid_o (awvalid_o), .awready_i (awready_i), .awaddr_o (awaddr_o),
    .wvalid_o (wvalid_o), .wready_i (wready_i), .wdata_o (wdata_o), .wstrb_o (wstrb_o),
    .bvalid_i (bvalid_i), .bready_o (bready_o), .bresp_i (bresp_i),
    .done_o (done_o), .done_err_o (done_err_o)
  );

endmodule
